// File: hw/color_pkg.sv
package color_pkg;

	// ------------------------------------------------------------------
	// pixel records, one per pipeline boundary
	// ------------------------------------------------------------------

	// decoder space, after the 4:2:2 demux
	typedef struct packed {
		logic       valid;
		logic       sof;	// first pixel of frame
		logic       eof;	// last pixel of frame
		logic [7:0] y;
		logic [7:0] cb;
		logic [7:0] cr;
	} ycc_pix_t;

	typedef struct packed {
		logic       valid;
		logic       sof;
		logic       eof;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_pix_t;

	typedef struct packed {
		logic       valid;
		logic       sof;
		logic       eof;
		logic [7:0] h;	// 0..239 hue circle
		logic [7:0] s;
		logic [7:0] v;
	} hsv_pix_t;

	// classified pixel, one mask word
	typedef struct packed {
		logic        valid;
		logic        sof;
		logic        eof;
		logic [15:0] mask;
	} mask_pix_t;

	// host read request, addr[16] picks the bank
	typedef struct packed {
		logic        sel;
		logic [16:0] addr;
	} host_req_t;

	// ------------------------------------------------------------------
	// enums
	// ------------------------------------------------------------------
	typedef enum logic [1:0] {PH_CB, PH_Y0, PH_CR, PH_Y1} byte_phase_e;
	typedef enum logic [1:0] {ARB_IDLE, ARB_READ} arb_state_e;

	// classifier limits
	localparam logic [7:0] HUE_WIN = 8'd10;	// half window
	localparam logic [7:0] SAT_MIN = 8'd96;
	localparam logic [7:0] VAL_MIN = 8'd96;

	// hue centers on the 240 step circle
	localparam logic [7:0] HUE_RED    = 8'd230;
	localparam logic [7:0] HUE_ORANGE = 8'd15;
	localparam logic [7:0] HUE_YELLOW = 8'd40;
	localparam logic [7:0] HUE_GREEN  = 8'd90;
	localparam logic [7:0] HUE_BLUE   = 8'd144;

endpackage

// File: hw/ycc_demux.sv
`timescale 1ns/1ps

module ycc_demux (
	input  logic                clk_llc,
	input  logic                resetx,
	input  logic                vref,	// frame sync
	input  logic                href,	// line sync
	input  logic [7:0]          vpo,	// Cb Y Cr Y byte stream
	output color_pkg::ycc_pix_t ycc_out
);

	color_pkg::byte_phase_e phase;
	color_pkg::ycc_pix_t    pix_q;
	logic [7:0] cb_q;
	logic [7:0] y0_q;
	logic [7:0] cr_q;
	logic       vref_d;
	logic       vref_rise;
	logic       sof_pend;	// armed on vref rise, spent on next pixel
	logic       y1_q;	// pix_q came from a Y1 byte
	logic       byte_en;
	logic       pix_en;

	assign byte_en   = vref & href;	// only active video counts
	assign vref_rise = vref & ~vref_d;
	assign pix_en    = byte_en && (phase == color_pkg::PH_CR || phase == color_pkg::PH_Y1);

	// byte position, back to Cb whenever href drops
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			phase <= color_pkg::PH_CB;
		else if (!href)
			phase <= color_pkg::PH_CB;
		else if (byte_en)
			phase <= color_pkg::byte_phase_e'(phase + 2'd1);	// wraps Y1 -> Cb
	end

	// chroma and first luma of the group
	always_ff @(posedge clk_llc)
	begin
		if (byte_en)
		begin
			case (phase)
				color_pkg::PH_CB: cb_q <= vpo;
				color_pkg::PH_Y0: y0_q <= vpo;
				color_pkg::PH_CR: cr_q <= vpo;
				default:          cb_q <= cb_q;	// Y1 goes straight out
			endcase
		end
	end

	// ------------------------------------------------------------------
	// pixel out, one after Cr (Y0) and one after Y1
	// ------------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			pix_q    <= '0;
			y1_q     <= 1'b0;
			vref_d   <= 1'b0;
			sof_pend <= 1'b0;
		end
		else
		begin
			vref_d      <= vref;
			pix_q.valid <= 1'b0;
			y1_q        <= 1'b0;
			if (vref_rise)
				sof_pend <= 1'b1;
			if (pix_en)
			begin
				pix_q.valid <= 1'b1;
				pix_q.sof   <= sof_pend | vref_rise;
				pix_q.cb    <= cb_q;
				pix_q.cr    <= (phase == color_pkg::PH_CR) ? vpo : cr_q;
				pix_q.y     <= (phase == color_pkg::PH_CR) ? y0_q : vpo;
				y1_q        <= (phase == color_pkg::PH_Y1);
				sof_pend    <= 1'b0;
			end
		end
	end

	// eof when vref has dropped right behind the last Y1 byte
	always_comb
	begin
		ycc_out     = pix_q;
		ycc_out.eof = pix_q.valid & y1_q & ~vref;
	end

	// pairs only, a Cb byte always separates two pairs
	assert property (@(posedge clk_llc) disable iff (!resetx)
		ycc_out.valid ##1 ycc_out.valid |=> !ycc_out.valid);

endmodule

// File: hw/ycc_to_rgb.sv
`timescale 1ns/1ps

module ycc_to_rgb (
	input  logic                clk_llc,
	input  logic                resetx,
	input  color_pkg::ycc_pix_t ycc_in,
	output color_pkg::rgb_pix_t rgb_out
);

	logic signed [10:0] y_ofs;	// 4Y - 64
	logic signed [10:0] cb_ofs;	// 4Cb - 512
	logic signed [10:0] cr_ofs;	// 4Cr - 512
	logic        [2:0]  ctl_q;	// valid sof eof
	logic signed [20:0] y_t;
	logic signed [20:0] r_t;
	logic signed [20:0] gr_t;
	logic signed [20:0] gb_t;
	logic signed [20:0] b_t;
	logic signed [20:0] r_sum;
	logic signed [20:0] g_sum;
	logic signed [20:0] b_sum;

	// below zero -> 0, 2^18 and up -> 255
	function automatic logic [7:0] clip8(input logic signed [20:0] v);
		if (v < 0)
			return 8'd0;
		else if (v >= 21'sd262144)
			return 8'hff;
		else
			return v[17:10];
	endfunction

	assign y_ofs  = $signed({1'b0, ycc_in.y, 2'b00}) - 11'sd64;
	assign cb_ofs = $signed({1'b0, ycc_in.cb, 2'b00}) - 11'sd512;
	assign cr_ofs = $signed({1'b0, ycc_in.cr, 2'b00}) - 11'sd512;

	// ------------------------------------------------------------------
	// stage 1, Q8 coefficient products
	// ------------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			ctl_q <= 3'b000;
		else
			ctl_q <= {ycc_in.valid, ycc_in.sof, ycc_in.eof};
	end

	always_ff @(posedge clk_llc)
	begin
		y_t  <= 21'sd298 * y_ofs;	// 1.164
		r_t  <= 21'sd409 * cr_ofs;	// 1.596
		gr_t <= 21'sd208 * cr_ofs;	// 0.813
		gb_t <= 21'sd100 * cb_ofs;	// 0.392
		b_t  <= 21'sd516 * cb_ofs;	// 2.017
	end

	// stage 2, sums and clip
	assign r_sum = y_t + r_t;
	assign g_sum = y_t - gr_t - gb_t;
	assign b_sum = y_t + b_t;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			rgb_out <= '0;
		else
		begin
			{rgb_out.valid, rgb_out.sof, rgb_out.eof} <= ctl_q;
			rgb_out.r <= clip8(r_sum);
			rgb_out.g <= clip8(g_sum);
			rgb_out.b <= clip8(b_sum);
		end
	end

endmodule

// File: hw/rgb_to_hsv.sv
`timescale 1ns/1ps

module rgb_to_hsv (
	input  logic                clk_llc,
	input  logic                resetx,
	input  color_pkg::rgb_pix_t rgb_in,
	output color_pkg::hsv_pix_t hsv_out
);

	logic        [7:0]  c_max;
	logic        [7:0]  c_min;
	logic signed [8:0]  c_diff;
	logic               c_mr;	// red is max
	logic               c_mg;	// green is max
	logic        [2:0]  s1_ctl;
	logic        [7:0]  s1_max;
	logic        [7:0]  s1_min;
	logic signed [8:0]  s1_diff;
	logic               s1_mr;
	logic               s1_mg;
	logic        [2:0]  s2_ctl;
	logic        [7:0]  s2_max;
	logic        [7:0]  s2_delta;
	logic signed [8:0]  s2_diff;
	logic               s2_mr;
	logic               s2_mg;
	logic signed [15:0] hq;	// 40 * diff / delta
	logic signed [15:0] h_full;
	logic        [15:0] s_full;

	// ------------------------------------------------------------------
	// stage 1, max, min and hue difference
	// ------------------------------------------------------------------
	always_comb
	begin
		c_mr = (rgb_in.r >= rgb_in.g) && (rgb_in.r >= rgb_in.b);
		c_mg = !c_mr && (rgb_in.g >= rgb_in.b);
		if (c_mr)
		begin
			c_max  = rgb_in.r;
			c_diff = $signed({1'b0, rgb_in.g}) - $signed({1'b0, rgb_in.b});
		end
		else if (c_mg)
		begin
			c_max  = rgb_in.g;
			c_diff = $signed({1'b0, rgb_in.b}) - $signed({1'b0, rgb_in.r});
		end
		else
		begin
			c_max  = rgb_in.b;
			c_diff = $signed({1'b0, rgb_in.r}) - $signed({1'b0, rgb_in.g});
		end
		if (rgb_in.r <= rgb_in.g && rgb_in.r <= rgb_in.b)
			c_min = rgb_in.r;
		else if (rgb_in.g <= rgb_in.b)
			c_min = rgb_in.g;
		else
			c_min = rgb_in.b;
	end

	// control flags, reset
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_ctl <= 3'b000;
			s2_ctl <= 3'b000;
		end
		else
		begin
			s1_ctl <= {rgb_in.valid, rgb_in.sof, rgb_in.eof};
			s2_ctl <= s1_ctl;
		end
	end

	// stage 1 and 2 data, stage 2 forms delta
	always_ff @(posedge clk_llc)
	begin
		s1_max   <= c_max;
		s1_min   <= c_min;
		s1_diff  <= c_diff;
		s1_mr    <= c_mr;
		s1_mg    <= c_mg;
		s2_max   <= s1_max;
		s2_delta <= s1_max - s1_min;
		s2_diff  <= s1_diff;
		s2_mr    <= s1_mr;
		s2_mg    <= s1_mg;
	end

	// ------------------------------------------------------------------
	// stage 3, divides
	// ------------------------------------------------------------------
	assign hq = (s2_diff * 16'sd40) / $signed({8'd0, s2_delta});	// truncates to zero

	always_comb
	begin
		if (s2_delta == 8'd0)
			h_full = 16'sd0;	// grey, no hue
		else if (s2_mr)
			h_full = (hq + 16'sd240) % 16'sd240;	// wrap negatives
		else if (s2_mg)
			h_full = hq + 16'sd80;
		else
			h_full = hq + 16'sd160;
	end

	assign s_full = (s2_max == 8'd0) ? 16'd0 : ({8'd0, s2_delta} * 16'd255) / {8'd0, s2_max};

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			hsv_out <= '0;
		else
		begin
			{hsv_out.valid, hsv_out.sof, hsv_out.eof} <= s2_ctl;
			hsv_out.h <= h_full[7:0];
			hsv_out.s <= s_full[7:0];
			hsv_out.v <= s2_max;	// value is the max channel
		end
	end

endmodule

// File: hw/color_classify.sv
`timescale 1ns/1ps

module color_classify (
	input  logic                 clk_llc,
	input  logic                 resetx,
	input  color_pkg::hsv_pix_t  hsv_in,
	output color_pkg::mask_pix_t mask_out
);

	logic [2:0] s1_ctl;
	logic       s1_black;
	logic       s1_col;	// bright and saturated
	logic [7:0] s1_h;
	logic       r_b;
	logic       o_b;
	logic       y_b;
	logic       g_b;
	logic       b_b;

	// open window, 8 bit wrap on both edges
	function automatic logic in_win(input logic [7:0] hue, input logic [7:0] center);
		logic [7:0] lo;
		logic [7:0] hi;
		lo = center - color_pkg::HUE_WIN;
		hi = center + color_pkg::HUE_WIN;
		return (lo < hue) && (hue < hi);
	endfunction

	// stage 1, black and saturation tests
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			s1_ctl   <= 3'b000;
			s1_black <= 1'b0;
			s1_col   <= 1'b0;
			s1_h     <= 8'd0;
		end
		else
		begin
			s1_ctl   <= {hsv_in.valid, hsv_in.sof, hsv_in.eof};
			s1_black <= hsv_in.v < color_pkg::VAL_MIN;
			s1_col   <= (hsv_in.v >= color_pkg::VAL_MIN) && (hsv_in.s > color_pkg::SAT_MIN);
			s1_h     <= hsv_in.h;
		end
	end

	// stage 2, hue windows
	assign r_b = s1_col & in_win(s1_h, color_pkg::HUE_RED);	// 220..240
	assign o_b = s1_col & in_win(s1_h, color_pkg::HUE_ORANGE);	// 5..25
	assign y_b = s1_col & in_win(s1_h, color_pkg::HUE_YELLOW);
	assign g_b = s1_col & in_win(s1_h, color_pkg::HUE_GREEN);
	assign b_b = s1_col & in_win(s1_h, color_pkg::HUE_BLUE);

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			mask_out <= '0;
		else
		begin
			{mask_out.valid, mask_out.sof, mask_out.eof} <= s1_ctl;
			mask_out.mask <= {
				r_b | o_b | y_b,	// 15 warm
				r_b | o_b | y_b | s1_black,
				r_b, o_b, y_b,
				g_b | y_b,	// 10
				g_b | y_b | o_b | s1_black,
				g_b | y_b | o_b,
				g_b, g_b, g_b,
				b_b,	// 4
				b_b | s1_black,
				b_b, b_b,
				s1_black	// 0
			};
		end
	end

endmodule

// File: hw/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
	parameter int FRAME_W = 180,
	parameter int FRAME_H = 120
) (
	input  logic                 clk_llc,
	input  logic                 resetx,
	input  color_pkg::mask_pix_t mask_in,
	input  color_pkg::host_req_t host_req,
	output logic                 host_ready,
	output logic [15:0]          host_rdata,
	output logic                 host_rvalid,
	output logic [1:0]           irq	// bit per finished bank
);

	localparam int DEPTH = FRAME_W * FRAME_H;
	localparam int AW    = $clog2(DEPTH);
	localparam int CW    = $clog2(FRAME_W);
	localparam int LW    = $clog2(FRAME_H + 1);	// room for the saturated count

	logic [15:0]           mem [2][DEPTH];
	color_pkg::arb_state_e arb_q;
	logic                  bank_q;
	logic [CW-1:0]         col_q;
	logic [LW-1:0]         line_q;
	logic                  wr_bank;
	logic [CW-1:0]         wr_col;
	logic [LW-1:0]         wr_line;
	logic [AW-1:0]         wr_addr;
	logic                  wr_en;
	logic                  accept;

	// ------------------------------------------------------------------
	// write side, sof restarts at address 0 of the other bank
	// ------------------------------------------------------------------
	assign wr_bank = mask_in.sof ? ~bank_q : bank_q;
	assign wr_col  = mask_in.sof ? '0 : col_q;
	assign wr_line = mask_in.sof ? '0 : line_q;
	assign wr_addr = AW'(wr_line * FRAME_W + wr_col);
	assign wr_en   = mask_in.valid && (wr_line < FRAME_H);	// drop overflow lines

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			bank_q <= 1'b1;	// first sof flips to bank 0
			col_q  <= '0;
			line_q <= '0;
		end
		else if (mask_in.valid)
		begin
			bank_q <= wr_bank;
			if (wr_col == CW'(FRAME_W - 1))
			begin
				col_q  <= '0;
				line_q <= (wr_line == LW'(FRAME_H)) ? wr_line : wr_line + 1'b1;
			end
			else
			begin
				col_q  <= wr_col + 1'b1;
				line_q <= wr_line;
			end
		end
	end

	always_ff @(posedge clk_llc)
	begin
		if (wr_en)
			mem[wr_bank][wr_addr] <= mask_in.mask;
	end

	// one cycle pulse after the eof write
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			irq <= 2'b00;
		else
		begin
			irq <= 2'b00;
			if (mask_in.valid && mask_in.eof)
				irq[wr_bank] <= 1'b1;
		end
	end

	// ------------------------------------------------------------------
	// host side, pixel writes own the single port
	// ------------------------------------------------------------------
	assign accept      = host_req.sel & ~mask_in.valid;
	assign host_ready  = accept;
	assign host_rvalid = (arb_q == color_pkg::ARB_READ);

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			arb_q <= color_pkg::ARB_IDLE;
		else
			arb_q <= accept ? color_pkg::ARB_READ : color_pkg::ARB_IDLE;
	end

	always_ff @(posedge clk_llc)
	begin
		if (accept)
			host_rdata <= mem[host_req.addr[16]][host_req.addr[AW-1:0]];
	end

	// column wraps inside the line
	assert property (@(posedge clk_llc) disable iff (!resetx) col_q < FRAME_W);
	// line count stops at the saturated value
	assert property (@(posedge clk_llc) disable iff (!resetx) line_q <= FRAME_H);

endmodule

// File: hw/color_tracker_top.sv
`timescale 1ns/1ps

module color_tracker_top #(
	parameter int FRAME_W = 180,
	parameter int FRAME_H = 120
) (
	input  logic                 clk_llc,
	input  logic                 resetx,
	input  logic                 vref,
	input  logic                 href,
	input  logic [7:0]           vpo,
	input  color_pkg::host_req_t host_req,
	output logic                 host_ready,
	output logic [15:0]          host_rdata,
	output logic                 host_rvalid,
	output logic [1:0]           irq
);

	color_pkg::ycc_pix_t  ycc_pix;
	color_pkg::rgb_pix_t  rgb_pix;
	color_pkg::hsv_pix_t  hsv_pix;
	color_pkg::mask_pix_t mask_pix;

	// ------------------------------------------------------------------
	// pixel chain, 8 cycles byte to buffer
	// ------------------------------------------------------------------
	ycc_demux ycc_demux_inst (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.vref    (vref),
		.href    (href),
		.vpo     (vpo),
		.ycc_out (ycc_pix)	// +1
	);

	ycc_to_rgb ycc_to_rgb_inst (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.ycc_in  (ycc_pix),
		.rgb_out (rgb_pix)	// +2
	);

	rgb_to_hsv rgb_to_hsv_inst (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.rgb_in  (rgb_pix),
		.hsv_out (hsv_pix)	// +3
	);

	color_classify color_classify_inst (
		.clk_llc  (clk_llc),
		.resetx   (resetx),
		.hsv_in   (hsv_pix),
		.mask_out (mask_pix)	// +2
	);

	frame_buffer #(
		.FRAME_W (FRAME_W),
		.FRAME_H (FRAME_H)
	) frame_buffer_inst (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.mask_in     (mask_pix),
		.host_req    (host_req),
		.host_ready  (host_ready),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.irq         (irq)
	);

endmodule

// File: test/color_tracker_model.svh
`ifndef COLOR_TRACKER_MODEL_SVH
`define COLOR_TRACKER_MODEL_SVH

// ----------------------------------------------------------------------
// expected pixel path, straight from the conversion and class rules
// ----------------------------------------------------------------------

// 10 fraction bits, saturate to a byte
function automatic logic [7:0] clip_byte(input int v);
	if (v < 0)
		return 8'd0;
	if (v >= (1 << 18))
		return 8'd255;
	return 8'(v >>> 10);
endfunction

// Q8 coefficients on 4x scaled offsets
function automatic logic [23:0] convert_rgb(input logic [7:0] y, input logic [7:0] cb,
	input logic [7:0] cr);
	int yt;
	int dcb;
	int dcr;
	yt  = 298 * (4 * int'(y) - 64);
	dcb = 4 * int'(cb) - 512;
	dcr = 4 * int'(cr) - 512;
	return {clip_byte(yt + 409 * dcr), clip_byte(yt - 208 * dcr - 100 * dcb),
		clip_byte(yt + 516 * dcb)};
endfunction

function automatic logic [23:0] convert_hsv(input logic [23:0] rgb);
	int r;
	int g;
	int b;
	int mx;
	int mn;
	int diff;
	int delta;
	int base;	// hue offset of the winning channel
	int h;
	r  = rgb[23:16];
	g  = rgb[15:8];
	b  = rgb[7:0];
	mn = (r < g) ? r : g;
	mn = (mn < b) ? mn : b;
	if (r >= g && r >= b)
	begin
		mx   = r;
		diff = g - b;
		base = 240;
	end
	else if (g >= b)
	begin
		mx   = g;
		diff = b - r;
		base = 80;
	end
	else
	begin
		mx   = b;
		diff = r - g;
		base = 160;
	end
	delta = mx - mn;
	h = (delta == 0) ? 0 : (40 * diff / delta + base) % 240;	// only red ever wraps
	return {8'(h), 8'((mx == 0) ? 0 : delta * 255 / mx), 8'(mx)};
endfunction

// strictly inside center +- window, 8 bit math
function automatic logic hue_inside(input logic [7:0] h, input logic [7:0] center);
	logic [7:0] lo;
	logic [7:0] hi;
	lo = center - color_pkg::HUE_WIN;
	hi = center + color_pkg::HUE_WIN;
	return (h > lo) && (h < hi);
endfunction

function automatic logic [15:0] expected_mask(input logic [7:0] y, input logic [7:0] cb,
	input logic [7:0] cr);
	logic [23:0] hsv;
	logic        blk;
	logic        col;
	logic        rd;
	logic        org;
	logic        yel;
	logic        grn;
	logic        blu;
	logic [15:0] m;
	hsv = convert_hsv(convert_rgb(y, cb, cr));
	blk = hsv[7:0] < color_pkg::VAL_MIN;
	col = !blk && (hsv[15:8] > color_pkg::SAT_MIN);
	rd  = col && hue_inside(hsv[23:16], color_pkg::HUE_RED);
	org = col && hue_inside(hsv[23:16], color_pkg::HUE_ORANGE);
	yel = col && hue_inside(hsv[23:16], color_pkg::HUE_YELLOW);
	grn = col && hue_inside(hsv[23:16], color_pkg::HUE_GREEN);
	blu = col && hue_inside(hsv[23:16], color_pkg::HUE_BLUE);
	m[15]  = rd | org | yel;	// warm group
	m[14]  = m[15] | blk;
	m[13]  = rd;
	m[12]  = org;
	m[11]  = yel;
	m[10]  = grn | yel;
	m[8]   = grn | yel | org;
	m[9]   = m[8] | blk;
	m[7:5] = {3{grn}};
	m[4]   = blu;
	m[3]   = blu | blk;
	m[2:1] = {2{blu}};
	m[0]   = blk;
	return m;
endfunction

`endif

// File: test/color_tracker_tb.sv
`timescale 1ns/1ps

module color_tracker_tb;

	localparam int FRAME_W     = 8;
	localparam int FRAME_H     = 4;
	localparam int PIX         = FRAME_W * FRAME_H;
	localparam int HBLANK      = 4;
	localparam int VBLANK      = 6;
	localparam int FRAME_CYC   = VBLANK + FRAME_H * (2 * FRAME_W + HBLANK + 1) + 10;
	localparam int READ_CYC    = 4 * PIX;	// one bank incl stalls
	localparam int TIMEOUT_CYC = 2 * (3 * FRAME_CYC + 3 * READ_CYC) + 5;

	logic                 clk_llc;
	logic                 resetx;
	logic                 vref;
	logic                 href;
	logic [7:0]           vpo;
	color_pkg::host_req_t host_req;
	logic                 host_ready;
	logic [15:0]          host_rdata;
	logic                 host_rvalid;
	logic [1:0]           irq;

	logic        pix_byte;	// byte on vpo completes a pixel
	logic [7:0]  wr_pipe;	// pixel bytes, delayed up to the write cycle
	logic [31:0] lcg_state;
	int          cycle_cnt;
	int          stall_cnt;	// host cycles lost to pixel writes
	logic [15:0] exp_mask [3][PIX];
	logic [1:0]  irq_log [$];

	// Cb Y0 Cr Y1 groups, one per class
	logic [31:0] color_grp [8] = '{
		32'h6C4CE442,	// red
		32'h4474C66A,	// orange
		32'h30A694B0,	// yellow
		32'h6774447E,	// green
		32'hD04C4E42,	// blue
		32'h80108028,	// black
		32'h809680C8,	// grey, no saturation
		32'h7674447E	// hue 100, top edge of green
	};

	`include "color_tracker_model.svh"

	color_tracker_top #(
		.FRAME_W (FRAME_W),
		.FRAME_H (FRAME_H)
	) color_tracker_top_inst (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.vref        (vref),
		.href        (href),
		.vpo         (vpo),
		.host_req    (host_req),
		.host_ready  (host_ready),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.irq         (irq)
	);

	always #2 clk_llc = ~clk_llc;	// 4 ns

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	function automatic logic [7:0] next_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];	// high bits, better period
	endfunction

	// ------------------------------------------------------------------
	// checks that run all the time
	// ------------------------------------------------------------------
	always @(posedge clk_llc)
	begin
		cycle_cnt <= cycle_cnt + 1;
		wr_pipe   <= {wr_pipe[6:0], pix_byte};	// bit 7 = buffer write now
		if (cycle_cnt >= TIMEOUT_CYC)
			report_fail($sformatf("timeout: run not done after %0d cycles", TIMEOUT_CYC));
		if (resetx && wr_pipe[7])
			assert (!host_ready)
			else report_fail("host_ready high in a pixel write cycle");
		if (resetx && irq != 2'b00)
			irq_log.push_back(irq);
	end

	assert property (@(posedge clk_llc)
		!resetx |-> (irq == 2'b00 && !host_ready && !host_rvalid))
	else report_fail("irq, host_ready or host_rvalid high during reset");

	assert property (@(posedge clk_llc) disable iff (!resetx) host_ready |=> host_rvalid)
	else report_fail("host_rvalid missing one cycle after accept");

	assert property (@(posedge clk_llc) disable iff (!resetx) !host_ready |=> !host_rvalid)
	else report_fail("host_rvalid without an accept");

	assert property (@(posedge clk_llc) disable iff (!resetx) (irq != 2'b00) |=> (irq == 2'b00))
	else report_fail("irq pulse longer than one cycle");

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	task automatic send_frame(input int f, input logic pick);
		logic [31:0] grp;
		int          a;
		@(posedge clk_llc);
		vref <= 1'b1;
		repeat (VBLANK) @(posedge clk_llc);
		for (int l = 0; l < FRAME_H; l++)
		begin
			for (int g = 0; g < FRAME_W / 2; g++)
			begin
				if (pick)
					grp = color_grp[(l * FRAME_W / 2 + g) % 8];
				else
					grp = {next_byte(), next_byte(), next_byte(), next_byte()};
				a = l * FRAME_W + 2 * g;
				exp_mask[f][a]     = expected_mask(grp[23:16], grp[31:24], grp[15:8]);
				exp_mask[f][a + 1] = expected_mask(grp[7:0], grp[31:24], grp[15:8]);
				for (int k = 0; k < 4; k++)
				begin
					@(posedge clk_llc);
					href     <= 1'b1;
					vpo      <= grp[31 - 8 * k -: 8];
					pix_byte <= (k >= 2);	// Cr and Y1
				end
			end
			@(posedge clk_llc);
			href     <= 1'b0;
			vpo      <= 8'h00;
			pix_byte <= 1'b0;
			if (l == FRAME_H - 1)
				vref <= 1'b0;	// drops right behind the last Y1
			repeat (HBLANK) @(posedge clk_llc);
		end
	endtask

	// hold the request until ready, look at outputs on the falling edge
	task automatic read_word(input logic bank, input int a, input logic [15:0] exp);
		@(posedge clk_llc);
		host_req.sel  <= 1'b1;
		host_req.addr <= {bank, 16'(a)};
		@(negedge clk_llc);
		while (!host_ready)
		begin
			stall_cnt++;
			@(negedge clk_llc);
		end
		@(posedge clk_llc);	// accept edge
		host_req <= '0;
		@(negedge clk_llc);
		assert (host_rdata == exp)
		else report_fail($sformatf("mismatch host_rdata bank %0d addr %0d: got %h, expected %h",
			bank, a, host_rdata, exp));
	endtask

	task automatic read_bank(input logic bank, input int f);
		for (int a = 0; a < PIX; a++)
			read_word(bank, a, exp_mask[f][a]);
	endtask

	task automatic wait_irq(input int n, input logic [1:0] exp);
		while (irq_log.size() < n)
			@(posedge clk_llc);
		assert (irq_log[n - 1] == exp)
		else report_fail($sformatf("mismatch irq: got %h, expected %h", irq_log[n - 1], exp));
	endtask

	initial
	begin
		clk_llc   = 1'b0;
		resetx    = 1'b0;
		vref      = 1'b0;
		href      = 1'b0;
		vpo       = 8'h00;
		host_req  = '0;
		pix_byte  = 1'b0;
		wr_pipe   = 8'h00;
		cycle_cnt = 0;
		stall_cnt = 0;
		lcg_state = 32'h4cc26919;
		repeat (5) @(posedge clk_llc);
		resetx <= 1'b1;
		repeat (3)
		begin
			@(negedge clk_llc);
			assert (irq == 2'b00 && !host_ready && !host_rvalid)
			else report_fail("outputs not idle right after reset");
		end
		send_frame(0, 1'b0);	// random, bank 0
		wait_irq(1, 2'b01);
		read_bank(1'b0, 0);
		send_frame(1, 1'b1);	// class patterns, bank 1
		wait_irq(2, 2'b10);
		fork
			send_frame(2, 1'b0);
			begin
				repeat (VBLANK + 4) @(posedge clk_llc);
				read_bank(1'b1, 1);	// older frame, against live writes
			end
		join
		wait_irq(3, 2'b01);
		read_bank(1'b0, 2);
		repeat (FRAME_CYC) @(posedge clk_llc);	// room for a stray pulse
		assert (irq_log.size() == 3)
		else report_fail($sformatf("mismatch irq pulse count: got %h, expected %h",
			irq_log.size(), 3));
		assert (stall_cnt > 0)
		else report_fail("host read never had to wait for a pixel write");
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// File: color_tracker_top.f
+incdir+test
hw/color_pkg.sv
hw/ycc_demux.sv
hw/ycc_to_rgb.sv
hw/rgb_to_hsv.sv
hw/color_classify.sv
hw/frame_buffer.sv
hw/color_tracker_top.sv
test/color_tracker_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the color tracker testbench, result comes from the printed pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f color_tracker_top.f \
	--top-module color_tracker_tb -o color_tracker_sim &&
./obj_dir/color_tracker_sim | grep "Simulation finished: PASS" ||
{ echo "color tracker simulation failed"; exit 1; }
